// File: include/btac_defines.svh
`ifndef BTAC_DEFINES_SVH
`define BTAC_DEFINES_SVH

// Table depths must be powers of two
`define BTB_DEPTH 64

`define BHT_DEPTH 128

`endif

// File: rtl/btac_pkg.sv
`include "btac_defines.svh"

package btac_pkg;

  localparam int btb_index_width = $clog2(`BTB_DEPTH);
  localparam int bht_index_width = $clog2(`BHT_DEPTH);
  localparam int btb_tag_width   = 31 - btb_index_width;  // PC bits above the index
  localparam int btb_entry_width = btb_tag_width + 32;    // Tag above a 32-bit target

  // Two-bit saturating counter where jal forces strongly taken
  function automatic logic [1:0] next_saturation(
    input logic [1:0] sat,
    input logic       jal,
    input logic       taken
  );
    logic [1:0] result;
    result = sat;
    if (jal) begin
      result = 2'd3;
    end else if (taken && sat != 2'd3) begin
      result = sat + 2'd1;
    end else if (!taken && sat != 2'd0) begin
      result = sat - 2'd1;
    end
    return result;
  endfunction

endpackage

// File: rtl/dual_read_ram.sv
`timescale 1ns/1ns

module dual_read_ram #(
  parameter int data_width = 32,
  parameter int depth      = 64
) (
  input  logic                     clock,
  input  logic                     wen,
  input  logic [$clog2(depth)-1:0] waddr,
  input  logic [$clog2(depth)-1:0] raddr0,
  input  logic [$clog2(depth)-1:0] raddr1,
  input  logic [data_width-1:0]    wdata,
  output logic [data_width-1:0]    rdata0,
  output logic [data_width-1:0]    rdata1
);

  logic [data_width-1:0] mem [0:depth-1] = '{default: '0};

  // Reads see the contents from before a same-cycle write
  always_ff @(posedge clock) begin
    if (wen) begin
      mem[waddr] <= wdata;
    end
    rdata0 <= mem[raddr0];
    rdata1 <= mem[raddr1];
  end

endmodule

// File: rtl/btac_ctrl.sv
`timescale 1ns/1ns

module btac_ctrl (
  input  logic                                  clock,
  input  logic                                  reset,
  input  logic                                  clear,
  input  logic                                  stall,
  input  logic [31:0]                           get_pc0,
  input  logic [31:0]                           get_pc1,
  input  logic [31:0]                           upd_pc0,
  input  logic [31:0]                           upd_npc0,
  input  logic [31:0]                           upd_addr0,
  input  logic                                  upd_branch0,
  input  logic                                  upd_jal0,
  input  logic                                  upd_jump0,
  input  logic                                  upd_pred_taken0,
  input  logic [31:0]                           upd_pred_taddr0,
  input  logic [1:0]                            upd_pred_tsat0,
  input  logic [31:0]                           upd_pc1,
  input  logic [31:0]                           upd_npc1,
  input  logic [31:0]                           upd_addr1,
  input  logic                                  upd_branch1,
  input  logic                                  upd_jal1,
  input  logic                                  upd_jump1,
  input  logic                                  upd_pred_taken1,
  input  logic [31:0]                           upd_pred_taddr1,
  input  logic [1:0]                            upd_pred_tsat1,
  output logic                                  pred_taken0,
  output logic                                  pred_taken1,
  output logic [31:0]                           pred_taddr0,
  output logic [31:0]                           pred_taddr1,
  output logic [1:0]                            pred_tsat0,
  output logic [1:0]                            pred_tsat1,
  output logic [31:0]                           pred_maddr,
  output logic                                  pred_miss,
  output logic                                  pred_hazard0,
  output logic                                  pred_hazard1,
  output logic                                  btb_wen,
  output logic [btac_pkg::btb_index_width-1:0]  btb_waddr,
  output logic [btac_pkg::btb_index_width-1:0]  btb_raddr0,
  output logic [btac_pkg::btb_index_width-1:0]  btb_raddr1,
  output logic [btac_pkg::btb_entry_width-1:0]  btb_wdata,
  input  logic [btac_pkg::btb_entry_width-1:0]  btb_rdata0,
  input  logic [btac_pkg::btb_entry_width-1:0]  btb_rdata1,
  output logic                                  bht_wen,
  output logic [btac_pkg::bht_index_width-1:0]  bht_waddr,
  output logic [btac_pkg::bht_index_width-1:0]  bht_raddr0,
  output logic [btac_pkg::bht_index_width-1:0]  bht_raddr1,
  output logic [1:0]                            bht_wdata,
  input  logic [1:0]                            bht_rdata0,
  input  logic [1:0]                            bht_rdata1
);

  import btac_pkg::*;

  logic [31:0]                pc0_q;
  logic [31:0]                pc1_q;
  logic [btb_index_width-1:0] btb_raddr0_q;
  logic [btb_index_width-1:0] btb_raddr1_q;
  logic [bht_index_width-1:0] bht_raddr0_q;
  logic [bht_index_width-1:0] bht_raddr1_q;
  logic                       upd_act0;
  logic                       upd_act1;
  logic                       tag_hit0;
  logic                       tag_hit1;
  logic                       hold;
  logic [32:0]                check0;
  logic [32:0]                check1;
  logic                       miss_q;
  logic [31:0]                maddr_q;

  // Returns {miss, correction address} for one retiring slot
  function automatic logic [32:0] miss_check(
    input logic        pred_taken,
    input logic        jump,
    input logic        branch,
    input logic [31:0] addr,
    input logic [31:0] npc,
    input logic [31:0] pred_taddr
  );
    logic [32:0] result;
    result = '0;
    if (pred_taken) begin
      if (jump) begin
        result = {addr != pred_taddr, addr};  // Wrong target
      end else if (branch) begin
        result = {1'b1, npc};                 // Predicted taken but fell through
      end
    end else if (jump) begin
      result = {1'b1, addr};
    end
    return result;
  endfunction

  // Read addresses freeze while clear is high
  assign btb_raddr0 = clear ? btb_raddr0_q : get_pc0[btb_index_width:1];
  assign btb_raddr1 = clear ? btb_raddr1_q : get_pc1[btb_index_width:1];
  assign bht_raddr0 = clear ? bht_raddr0_q : get_pc0[bht_index_width:1];
  assign bht_raddr1 = clear ? bht_raddr1_q : get_pc1[bht_index_width:1];

  always_ff @(posedge clock) begin
    if (!reset) begin
      btb_raddr0_q <= '0;
      btb_raddr1_q <= '0;
      bht_raddr0_q <= '0;
      bht_raddr1_q <= '0;
      pc0_q        <= '0;
      pc1_q        <= '0;
      miss_q       <= 1'b0;
    end else begin
      btb_raddr0_q <= btb_raddr0;
      btb_raddr1_q <= btb_raddr1;
      bht_raddr0_q <= bht_raddr0;
      bht_raddr1_q <= bht_raddr1;
      if (!clear) begin
        pc0_q <= get_pc0;
        pc1_q <= get_pc1;
      end
      miss_q <= pred_hazard0 | pred_hazard1;
    end
  end

  // Slot 0 wins when both slots retire a control transfer
  assign upd_act0 = upd_jal0 | upd_branch0;
  assign upd_act1 = upd_jal1 | upd_branch1;

  assign btb_wen   = ~clear & (upd_act0 | upd_act1);
  assign btb_waddr = upd_act0 ? upd_pc0[btb_index_width:1] : upd_pc1[btb_index_width:1];
  assign btb_wdata = upd_act0 ? {upd_pc0[31:btb_index_width+1], upd_addr0}
                              : {upd_pc1[31:btb_index_width+1], upd_addr1};

  assign bht_wen   = btb_wen;
  assign bht_waddr = upd_act0 ? upd_pc0[bht_index_width:1] : upd_pc1[bht_index_width:1];
  assign bht_wdata = upd_act0 ? next_saturation(upd_pred_tsat0, upd_jal0, upd_jump0)
                              : next_saturation(upd_pred_tsat1, upd_jal1, upd_jump1);

  // Prediction from this cycle's table data and last cycle's PCs
  assign hold     = stall | clear;
  assign tag_hit0 = btb_rdata0[btb_entry_width-1:32] == pc0_q[31:btb_index_width+1];
  assign tag_hit1 = btb_rdata1[btb_entry_width-1:32] == pc1_q[31:btb_index_width+1];

  assign pred_taken0 = hold ? 1'b0 : bht_rdata0[1] & tag_hit0;
  assign pred_taken1 = hold ? 1'b0 : bht_rdata1[1] & tag_hit1;
  assign pred_taddr0 = hold ? 32'd0 : btb_rdata0[31:0];
  assign pred_taddr1 = hold ? 32'd0 : btb_rdata1[31:0];
  assign pred_tsat0  = hold ? 2'd0 : bht_rdata0;
  assign pred_tsat1  = hold ? 2'd0 : bht_rdata1;

  assign check0 = miss_check(upd_pred_taken0, upd_jump0, upd_branch0,
                             upd_addr0, upd_npc0, upd_pred_taddr0);
  assign check1 = miss_check(upd_pred_taken1, upd_jump1, upd_branch1,
                             upd_addr1, upd_npc1, upd_pred_taddr1);

  assign pred_hazard0 = check0[32];
  assign pred_hazard1 = check1[32];

  always_ff @(posedge clock) begin
    maddr_q <= pred_hazard0 ? check0[31:0] : check1[31:0];  // Older slot first
  end

  assign pred_miss  = miss_q;
  assign pred_maddr = maddr_q;

endmodule

// File: rtl/btac.sv
`timescale 1ns/1ns

`include "btac_defines.svh"

module btac (
  input  logic        clock,
  input  logic        reset,
  input  logic        clear,
  input  logic        stall,
  input  logic [31:0] get_pc0,
  input  logic [31:0] get_pc1,
  input  logic [31:0] upd_pc0,
  input  logic [31:0] upd_npc0,
  input  logic [31:0] upd_addr0,
  input  logic        upd_branch0,
  input  logic        upd_jal0,
  input  logic        upd_jump0,
  input  logic        upd_pred_taken0,
  input  logic [31:0] upd_pred_taddr0,
  input  logic [1:0]  upd_pred_tsat0,
  input  logic [31:0] upd_pc1,
  input  logic [31:0] upd_npc1,
  input  logic [31:0] upd_addr1,
  input  logic        upd_branch1,
  input  logic        upd_jal1,
  input  logic        upd_jump1,
  input  logic        upd_pred_taken1,
  input  logic [31:0] upd_pred_taddr1,
  input  logic [1:0]  upd_pred_tsat1,
  output logic        pred_taken0,
  output logic        pred_taken1,
  output logic [31:0] pred_taddr0,
  output logic [31:0] pred_taddr1,
  output logic [1:0]  pred_tsat0,
  output logic [1:0]  pred_tsat1,
  output logic [31:0] pred_maddr,
  output logic        pred_miss,
  output logic        pred_hazard0,
  output logic        pred_hazard1
);

  import btac_pkg::*;

  logic                       btb_wen;
  logic [btb_index_width-1:0] btb_waddr;
  logic [btb_index_width-1:0] btb_raddr0;
  logic [btb_index_width-1:0] btb_raddr1;
  logic [btb_entry_width-1:0] btb_wdata;
  logic [btb_entry_width-1:0] btb_rdata0;
  logic [btb_entry_width-1:0] btb_rdata1;
  logic                       bht_wen;
  logic [bht_index_width-1:0] bht_waddr;
  logic [bht_index_width-1:0] bht_raddr0;
  logic [bht_index_width-1:0] bht_raddr1;
  logic [1:0]                 bht_wdata;
  logic [1:0]                 bht_rdata0;
  logic [1:0]                 bht_rdata1;

  // Tag and target per entry
  dual_read_ram #(
    .data_width(btb_entry_width),
    .depth     (`BTB_DEPTH)
  ) btb_ram (
    .clock (clock),
    .wen   (btb_wen),
    .waddr (btb_waddr),
    .raddr0(btb_raddr0),
    .raddr1(btb_raddr1),
    .wdata (btb_wdata),
    .rdata0(btb_rdata0),
    .rdata1(btb_rdata1)
  );

  // Two-bit counters
  dual_read_ram #(
    .data_width(2),
    .depth     (`BHT_DEPTH)
  ) bht_ram (
    .clock (clock),
    .wen   (bht_wen),
    .waddr (bht_waddr),
    .raddr0(bht_raddr0),
    .raddr1(bht_raddr1),
    .wdata (bht_wdata),
    .rdata0(bht_rdata0),
    .rdata1(bht_rdata1)
  );

  btac_ctrl btac_ctrl_i (
    .clock          (clock),
    .reset          (reset),
    .clear          (clear),
    .stall          (stall),
    .get_pc0        (get_pc0),
    .get_pc1        (get_pc1),
    .upd_pc0        (upd_pc0),
    .upd_npc0       (upd_npc0),
    .upd_addr0      (upd_addr0),
    .upd_branch0    (upd_branch0),
    .upd_jal0       (upd_jal0),
    .upd_jump0      (upd_jump0),
    .upd_pred_taken0(upd_pred_taken0),
    .upd_pred_taddr0(upd_pred_taddr0),
    .upd_pred_tsat0 (upd_pred_tsat0),
    .upd_pc1        (upd_pc1),
    .upd_npc1       (upd_npc1),
    .upd_addr1      (upd_addr1),
    .upd_branch1    (upd_branch1),
    .upd_jal1       (upd_jal1),
    .upd_jump1      (upd_jump1),
    .upd_pred_taken1(upd_pred_taken1),
    .upd_pred_taddr1(upd_pred_taddr1),
    .upd_pred_tsat1 (upd_pred_tsat1),
    .pred_taken0    (pred_taken0),
    .pred_taken1    (pred_taken1),
    .pred_taddr0    (pred_taddr0),
    .pred_taddr1    (pred_taddr1),
    .pred_tsat0     (pred_tsat0),
    .pred_tsat1     (pred_tsat1),
    .pred_maddr     (pred_maddr),
    .pred_miss      (pred_miss),
    .pred_hazard0   (pred_hazard0),
    .pred_hazard1   (pred_hazard1),
    .btb_wen        (btb_wen),
    .btb_waddr      (btb_waddr),
    .btb_raddr0     (btb_raddr0),
    .btb_raddr1     (btb_raddr1),
    .btb_wdata      (btb_wdata),
    .btb_rdata0     (btb_rdata0),
    .btb_rdata1     (btb_rdata1),
    .bht_wen        (bht_wen),
    .bht_waddr      (bht_waddr),
    .bht_raddr0     (bht_raddr0),
    .bht_raddr1     (bht_raddr1),
    .bht_wdata      (bht_wdata),
    .bht_rdata0     (bht_rdata0),
    .bht_rdata1     (bht_rdata1)
  );

endmodule

// File: verif/btac_assert.sv
`timescale 1ns/1ns

module btac_assert (
  input logic clock,
  input logic reset,
  input logic stall,
  input logic clear,
  input logic pred_taken0,
  input logic pred_taken1,
  input logic pred_miss,
  input logic pred_hazard0,
  input logic pred_hazard1
);

  int assert_errors = 0;

  // Outputs held at zero for a stalled or cleared lookup
  hold_zeroes_taken: assert property (@(posedge clock) disable iff (!reset)
    (stall || clear) |-> !(pred_taken0 || pred_taken1))
    else begin
      assert_errors++;
      $error("pred_taken set while stall or clear was high");
    end

  miss_low_after_reset: assert property (@(posedge clock) !reset |=> !pred_miss)
    else begin
      assert_errors++;
      $error("pred_miss set in the cycle after reset");
    end

  miss_follows_hazard: assert property (@(posedge clock) disable iff (!reset)
    reset |=> pred_miss == $past(pred_hazard0 || pred_hazard1))
    else begin
      assert_errors++;
      $error("pred_miss does not follow the hazard outputs of the previous cycle");
    end

endmodule

bind btac btac_assert btac_assert_i (
  .clock       (clock),
  .reset       (reset),
  .stall       (stall),
  .clear       (clear),
  .pred_taken0 (pred_taken0),
  .pred_taken1 (pred_taken1),
  .pred_miss   (pred_miss),
  .pred_hazard0(pred_hazard0),
  .pred_hazard1(pred_hazard1)
);

// File: verif/btac_tb.sv
`timescale 1ns/1ns

`include "btac_defines.svh"

module btac_tb;

  import btac_pkg::*;

  logic        clock = 1'b0;
  logic        reset;
  logic        clear;
  logic        stall;
  logic [31:0] get_pc0;
  logic [31:0] get_pc1;
  logic [31:0] upd_pc0, upd_npc0, upd_addr0, upd_pred_taddr0;
  logic [31:0] upd_pc1, upd_npc1, upd_addr1, upd_pred_taddr1;
  logic        upd_branch0, upd_jal0, upd_jump0, upd_pred_taken0;
  logic        upd_branch1, upd_jal1, upd_jump1, upd_pred_taken1;
  logic [1:0]  upd_pred_tsat0, upd_pred_tsat1;
  logic        pred_taken0, pred_taken1, pred_miss, pred_hazard0, pred_hazard1;
  logic [31:0] pred_taddr0, pred_taddr1, pred_maddr;
  logic [1:0]  pred_tsat0, pred_tsat1;

  // Update slots as seen by the model and copied onto the DUT ports each cycle
  logic [31:0] u_pc [2];
  logic [31:0] u_npc [2];
  logic [31:0] u_addr [2];
  logic [31:0] u_ptaddr [2];
  logic        u_branch [2];
  logic        u_jal [2];
  logic        u_jump [2];
  logic        u_ptaken [2];
  logic [1:0]  u_tsat [2];

  logic [btb_tag_width-1:0] model_tag [`BTB_DEPTH] = '{default: '0};
  logic [31:0]              model_target [`BTB_DEPTH] = '{default: '0};
  logic [1:0]               model_bht [`BHT_DEPTH] = '{default: '0};
  logic [31:0]              pc_pool [8];
  logic [31:0]              lcg_state = 32'h554;
  string                    current_test;
  int                       test_errors = 0;
  int                       total_errors = 0;
  int                       tests_passed = 0;
  int                       tests_failed = 0;

  btac btac_i (.*);

  always #2 clock = ~clock;

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] pick_pc();
    logic [31:0] r;
    r = next_random();
    return pc_pool[r[31:29]];
  endfunction

  function automatic logic [btb_index_width-1:0] btb_index(input logic [31:0] pc);
    return pc[btb_index_width:1];
  endfunction

  function automatic logic [bht_index_width-1:0] bht_index(input logic [31:0] pc);
    return pc[bht_index_width:1];
  endfunction

  function automatic logic [btb_tag_width-1:0] btb_tag(input logic [31:0] pc);
    return pc[31:btb_index_width+1];
  endfunction

  // Jal sets the counter to 3 and a branch counts toward its outcome
  function automatic logic [1:0] trained_counter(input logic [1:0] sat, input logic jal,
                                                 input logic taken);
    if (jal) begin
      return 2'd3;
    end
    if (taken) begin
      return (sat == 2'd3) ? 2'd3 : sat + 2'd1;
    end
    return (sat == 2'd0) ? 2'd0 : sat - 2'd1;
  endfunction

  // Three miss rules for one retiring slot
  function automatic logic slot_misses(input logic s);
    if (u_ptaken[s]) begin
      return u_jump[s] ? (u_addr[s] != u_ptaddr[s]) : u_branch[s];
    end
    return u_jump[s];
  endfunction

  function automatic logic [31:0] correction(input logic s);
    return (u_ptaken[s] && !u_jump[s]) ? u_npc[s] : u_addr[s];
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s %s expected %0h actual %0h", current_test, name,
               expected, actual);
      test_errors++;
      total_errors++;
    end
  endtask

  task automatic begin_test(input string name);
    current_test = name;
    test_errors  = 0;
  endtask

  task automatic end_test();
    if (test_errors == 0) begin
      $display("PASS %s", current_test);
      tests_passed++;
    end else begin
      $display("FAIL %s with %0d mismatches", current_test, test_errors);
      tests_failed++;
    end
  endtask

  task automatic clear_slots();
    for (int s = 0; s < 2; s++) begin
      u_pc[s]     = 32'd0;
      u_npc[s]    = 32'd0;
      u_addr[s]   = 32'd0;
      u_ptaddr[s] = 32'd0;
      u_branch[s] = 1'b0;
      u_jal[s]    = 1'b0;
      u_jump[s]   = 1'b0;
      u_ptaken[s] = 1'b0;
      u_tsat[s]   = 2'd0;
    end
  endtask

  task automatic drive_slots();
    upd_pc0 <= u_pc[0];
    upd_npc0 <= u_npc[0];
    upd_addr0 <= u_addr[0];
    upd_pred_taddr0 <= u_ptaddr[0];
    upd_branch0 <= u_branch[0];
    upd_jal0 <= u_jal[0];
    upd_jump0 <= u_jump[0];
    upd_pred_taken0 <= u_ptaken[0];
    upd_pred_tsat0 <= u_tsat[0];
    upd_pc1 <= u_pc[1];
    upd_npc1 <= u_npc[1];
    upd_addr1 <= u_addr[1];
    upd_pred_taddr1 <= u_ptaddr[1];
    upd_branch1 <= u_branch[1];
    upd_jal1 <= u_jal[1];
    upd_jump1 <= u_jump[1];
    upd_pred_taken1 <= u_ptaken[1];
    upd_pred_tsat1 <= u_tsat[1];
  endtask

  // One training write per cycle with slot 0 first
  task automatic model_write(input logic clr);
    logic s;
    if (!clr && (u_jal[0] || u_branch[0] || u_jal[1] || u_branch[1])) begin
      s = !(u_jal[0] || u_branch[0]);
      model_tag[btb_index(u_pc[s])]    = btb_tag(u_pc[s]);
      model_target[btb_index(u_pc[s])] = u_addr[s];
      model_bht[bht_index(u_pc[s])]    = trained_counter(u_tsat[s], u_jal[s], u_jump[s]);
    end
  endtask

  task automatic issue_update(input logic clr);
    @(posedge clock);
    drive_slots();
    clear <= clr;
    stall <= 1'b0;
    model_write(clr);
  endtask

  task automatic random_slot(input logic s);
    logic [31:0] r;
    logic [31:0] target;
    r = next_random();
    target = next_random();
    u_pc[s]     = pick_pc();
    u_npc[s]    = u_pc[s] + 32'd4;
    u_addr[s]   = {target[31:2], 2'b00};
    u_jal[s]    = r[31] & r[30];  // About a quarter are jal
    u_branch[s] = !u_jal[s] & r[29];
    u_jump[s]   = u_jal[s] | (u_branch[s] & r[28]);
    u_ptaken[s] = r[27];
    u_ptaddr[s] = r[26] ? u_addr[s] : u_addr[s] ^ 32'h40;
    u_tsat[s]   = model_bht[bht_index(u_pc[s])];
  endtask

  task automatic train_branch(input logic [31:0] pc, input logic taken);
    clear_slots();
    u_pc[0]     = pc;
    u_npc[0]    = pc + 32'd4;
    u_addr[0]   = 32'h0000_0800;
    u_branch[0] = 1'b1;
    u_jump[0]   = taken;
    u_tsat[0]   = model_bht[bht_index(pc)];
    issue_update(1'b0);
  endtask

  task automatic check_slot(input string name, input logic [31:0] pc, input logic held,
                            input logic taken, input logic [31:0] taddr,
                            input logic [1:0] tsat);
    logic [1:0] sat;
    logic       hit;
    sat = model_bht[bht_index(pc)];
    hit = model_tag[btb_index(pc)] == btb_tag(pc);
    check_value({name, " taken"}, held ? 32'd0 : 32'(sat[1] & hit), 32'(taken));
    check_value({name, " target"}, held ? 32'd0 : model_target[btb_index(pc)], taddr);
    check_value({name, " counter"}, held ? 32'd0 : 32'(sat), 32'(tsat));
  endtask

  // PCs presented in one cycle and predictions compared in the next
  task automatic lookup_check(input logic [31:0] pc0, input logic [31:0] pc1,
                              input logic st, input logic cl, input string name);
    clear_slots();
    @(posedge clock);
    drive_slots();
    clear   <= 1'b0;
    stall   <= 1'b0;
    get_pc0 <= pc0;
    get_pc1 <= pc1;
    @(posedge clock);
    stall <= st;
    clear <= cl;
    @(negedge clock);
    check_slot({name, " slot0"}, pc0, st | cl, pred_taken0, pred_taddr0, pred_tsat0);
    check_slot({name, " slot1"}, pc1, st | cl, pred_taken1, pred_taddr1, pred_tsat1);
  endtask

  initial begin
    #200000;
    $display("Watchdog timeout: simulation ran too long");
    $display("Test failed");
    $finish;
  end

  initial begin
    logic        exp_h0;
    logic        exp_h1;
    logic        prev_miss;
    logic [31:0] prev_maddr;
    int          j;
    pc_pool = '{32'h0000_1004, 32'h0000_2004, 32'h0000_1084, 32'h0000_3010,
                32'h0000_4010, 32'h0000_0120, 32'h0000_8a3c, 32'h0001_0a3c};
    reset   <= 1'b0;
    clear   <= 1'b0;
    stall   <= 1'b0;
    get_pc0 <= 32'd0;
    get_pc1 <= 32'd0;
    clear_slots();
    u_jump[0] = 1'b1;  // Hazard without a table write while reset is low
    drive_slots();
    repeat (5) @(posedge clock);
    reset <= 1'b1;
    clear_slots();
    drive_slots();

    begin_test("reset");
    @(negedge clock);
    check_value("reset pred_miss", 32'd0, 32'(pred_miss));
    lookup_check(pc_pool[0], pc_pool[5], 1'b0, 1'b0, "reset lookup");
    lookup_check(pc_pool[2], pc_pool[7], 1'b0, 1'b0, "reset lookup");
    end_test();

    begin_test("training and lookup");
    for (int n = 0; n < 48; n++) begin
      random_slot(1'b0);
      random_slot(1'b1);
      issue_update(1'b0);
    end
    for (int i = 0; i < 8; i++) begin
      j = (i + 3) % 8;
      lookup_check(pc_pool[i[2:0]], pc_pool[j[2:0]], 1'b0, 1'b0, "training lookup");
    end
    end_test();

    begin_test("saturation and priority");
    for (int n = 0; n < 5; n++) train_branch(pc_pool[5], 1'b1);
    lookup_check(pc_pool[5], pc_pool[0], 1'b0, 1'b0, "saturate up");
    check_value("saturate up bound", 32'd3, 32'(pred_tsat0));
    for (int n = 0; n < 5; n++) train_branch(pc_pool[5], 1'b0);
    lookup_check(pc_pool[5], pc_pool[0], 1'b0, 1'b0, "saturate down");
    check_value("saturate down bound", 32'd0, 32'(pred_tsat0));
    clear_slots();
    u_pc[0]   = pc_pool[3];
    u_npc[0]  = pc_pool[3] + 32'd4;
    u_addr[0] = 32'h0000_a000;
    u_jal[0]  = 1'b1;
    u_jump[0] = 1'b1;
    u_pc[1]   = pc_pool[6];
    u_npc[1]  = pc_pool[6] + 32'd4;
    u_addr[1] = 32'h0000_b000;
    u_jal[1]  = 1'b1;
    u_jump[1] = 1'b1;
    issue_update(1'b0);
    lookup_check(pc_pool[3], pc_pool[6], 1'b0, 1'b0, "priority");
    check_value("priority slot0 target", 32'h0000_a000, pred_taddr0);
    check_value("priority slot1 unwritten", 32'd0, 32'(pred_taddr1 == 32'h0000_b000));
    end_test();

    begin_test("misprediction");
    prev_miss  = 1'b0;  // Last lookup cycle had no hazard
    prev_maddr = 32'd0;
    for (int n = 0; n < 40; n++) begin
      random_slot(1'b0);
      random_slot(1'b1);
      issue_update(1'b0);
      @(negedge clock);
      exp_h0 = slot_misses(1'b0);
      exp_h1 = slot_misses(1'b1);
      check_value("miss hazard0", 32'(exp_h0), 32'(pred_hazard0));
      check_value("miss hazard1", 32'(exp_h1), 32'(pred_hazard1));
      check_value("miss pred_miss", 32'(prev_miss), 32'(pred_miss));
      if (prev_miss) check_value("miss pred_maddr", prev_maddr, pred_maddr);
      prev_miss  = exp_h0 | exp_h1;
      prev_maddr = exp_h0 ? correction(1'b0) : correction(1'b1);
    end
    clear_slots();
    @(posedge clock);
    drive_slots();
    @(negedge clock);
    check_value("miss pred_miss last", 32'(prev_miss), 32'(pred_miss));
    if (prev_miss) check_value("miss pred_maddr last", prev_maddr, pred_maddr);
    end_test();

    begin_test("stall and clear");
    lookup_check(pc_pool[0], pc_pool[3], 1'b1, 1'b0, "stalled lookup");
    lookup_check(pc_pool[0], pc_pool[3], 1'b0, 1'b0, "after stall");
    lookup_check(pc_pool[1], pc_pool[6], 1'b0, 1'b1, "cleared lookup");
    for (int n = 0; n < 8; n++) begin
      random_slot(1'b0);
      random_slot(1'b1);
      issue_update(1'b1);
    end
    for (int i = 0; i < 8; i++) begin
      j = (i + 5) % 8;
      lookup_check(pc_pool[i[2:0]], pc_pool[j[2:0]], 1'b0, 1'b0, "after clear");
    end
    end_test();

    total_errors += btac_i.btac_assert_i.assert_errors;
    $display("Summary: %0d passed, %0d failed, %0d mismatches, %0d assertion errors",
             tests_passed, tests_failed, total_errors - btac_i.btac_assert_i.assert_errors,
             btac_i.btac_assert_i.assert_errors);
    if (total_errors == 0 && tests_failed == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+include
rtl/btac_pkg.sv
rtl/dual_read_ram.sv
rtl/btac_ctrl.sv
rtl/btac.sv
verif/btac_assert.sv
verif/btac_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= btac_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o V$(TOP)

sim: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then \
	  echo "Simulation reported failure, see $(LOG)"; exit 1; \
	elif grep -q "Test completed successfully" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
